// File: sim.f
src/uart_pkg.sv
src/uart_baud_gen.sv
src/uart_fifo.sv
src/uart_transmitter.sv
src/uart_receiver.sv
src/uart_wb_regs.sv
src/uart_top.sv
testbench/tb_clock_gen.sv
testbench/uart_props.sv
testbench/uart_tb.sv

// File: testbench/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;
    import uart_pkg::*;

    typedef enum {
        OP_WRITE, OP_READ, OP_STATUS, OP_POLL, OP_SEND, OP_LINE, OP_FRAME, OP_TIMED
    } op_e;

    typedef struct {
        op_e                  op;
        reg_addr_e            addr;
        logic [DATA_BITS-1:0] wdata;
        logic [DATA_BITS-1:0] exp;                // Read data or status value
        logic [DATA_BITS-1:0] mask;               // Status bits under test
    } row_t;

    localparam logic [DATA_BITS-1:0] M_TX_FULL   = DATA_BITS'(1 << ST_TX_FULL);
    localparam logic [DATA_BITS-1:0] M_TX_EMPTY  = DATA_BITS'(1 << ST_TX_EMPTY);
    localparam logic [DATA_BITS-1:0] M_RX_EMPTY  = DATA_BITS'(1 << ST_RX_EMPTY);
    localparam logic [DATA_BITS-1:0] M_RX_FULL   = DATA_BITS'(1 << ST_RX_FULL);
    localparam logic [DATA_BITS-1:0] M_OVERRUN   = DATA_BITS'(1 << ST_OVERRUN);
    localparam logic [DATA_BITS-1:0] M_FRAME_ERR = DATA_BITS'(1 << ST_FRAME_ERR);

    logic                     clk, rst;
    logic                     wb_cyc, wb_stb, wb_we, wb_ack;
    logic [WB_ADDR_WIDTH-1:0] wb_adr;
    logic [DATA_BITS-1:0]     wb_dat_w, wb_dat_r;
    logic                     dut_tx, dut_rx, rx_drive, loop_en;
    row_t                     rows[$];
    int                       cur_div = DIV_RESET;  // Divisor as last written
    int                       max_div = DIV_RESET;
    longint                   cycles = 0;

    tb_clock_gen clock_gen_i (.o_clk(clk), .o_reset(rst));

    assign dut_rx = loop_en ? dut_tx : rx_drive;  // Loopback unless driving frames

    uart_top uart_top_i (
        .i_clk(clk), .i_reset(rst), .i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb), .i_wb_we(wb_we),
        .i_wb_adr(wb_adr), .i_wb_dat(wb_dat_w), .o_wb_dat(wb_dat_r), .o_wb_ack(wb_ack),
        .i_rx(dut_rx), .o_tx(dut_tx)
    );

    always @(posedge clk) cycles <= cycles + 1;

    always @(posedge clk) begin
        if (uart_top_i.uart_wb_regs_i.wb_props_i.fail_count != 0 ||
            uart_top_i.uart_transmitter_i.tx_props_i.fail_count != 0) begin
            stop_run("A bound assertion failed during the run");
        end
    end

    function automatic void add_row(op_e op, reg_addr_e addr, logic [DATA_BITS-1:0] wdata,
                                    logic [DATA_BITS-1:0] exp, logic [DATA_BITS-1:0] mask);
        rows.push_back('{op, addr, wdata, exp, mask});
        if (op == OP_WRITE && addr == ADDR_DIVISOR && int'(wdata) > max_div) begin
            max_div = wdata;
        end
    endfunction

    function automatic void add_loopback(logic [DATA_BITS-1:0] b);
        add_row(OP_SEND, ADDR_DATA, b, 8'h00, 8'h00);
        add_row(OP_POLL, ADDR_STATUS, 8'h00, 8'h00, M_RX_EMPTY);
        add_row(OP_READ, ADDR_DATA, 8'h00, b, 8'h00);
    endfunction

    function automatic void build_table();
        logic [DATA_BITS-1:0] b;
        logic [DATA_BITS-1:0] burst[10];
        logic [DATA_BITS-1:0] flood[17];
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_TX_EMPTY | M_RX_EMPTY, 8'h3f);
        add_row(OP_LINE, ADDR_DATA, 8'h01, 8'h00, 8'h00);
        add_row(OP_READ, ADDR_DATA, 8'h00, 8'h00, 8'h00);      // Empty FIFO reads 0
        add_row(OP_READ, ADDR_DIVISOR, 8'h00, 8'h01, 8'h00);   // Divisor resets to 1
        add_loopback(8'h00);
        add_loopback(8'hff);
        add_loopback(8'h55);
        for (int i = 0; i < 3; i++) add_loopback(DATA_BITS'($urandom));
        // Shift register takes the first byte and the FIFO the next eight
        for (int i = 0; i < 10; i++) burst[i] = DATA_BITS'($urandom);
        for (int i = 0; i < 9; i++) add_row(OP_WRITE, ADDR_DATA, burst[i], 8'h00, 8'h00);
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_TX_FULL, M_TX_FULL);
        add_row(OP_WRITE, ADDR_DATA, burst[9], 8'h00, 8'h00);  // Lost
        for (int i = 0; i < 9; i++) begin
            add_row(OP_POLL, ADDR_STATUS, 8'h00, 8'h00, M_RX_EMPTY);
            add_row(OP_READ, ADDR_DATA, 8'h00, burst[i], 8'h00);
        end
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_TX_EMPTY | M_RX_EMPTY,
                M_TX_FULL | M_TX_EMPTY | M_RX_EMPTY);
        // One byte more than the RX FIFO holds
        for (int i = 0; i < 17; i++) begin
            flood[i] = DATA_BITS'($urandom);
            add_row(OP_SEND, ADDR_DATA, flood[i], 8'h00, 8'h00);
        end
        add_row(OP_POLL, ADDR_STATUS, 8'h00, M_OVERRUN, M_OVERRUN);
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_RX_FULL, M_RX_FULL | M_OVERRUN);
        for (int i = 0; i < 16; i++) add_row(OP_READ, ADDR_DATA, 8'h00, flood[i], 8'h00);
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_RX_EMPTY, M_RX_EMPTY | M_OVERRUN);
        b = DATA_BITS'($urandom);
        add_row(OP_FRAME, ADDR_DATA, b, 8'h00, 8'h00);
        add_row(OP_POLL, ADDR_STATUS, 8'h00, M_FRAME_ERR, M_FRAME_ERR);
        add_row(OP_READ, ADDR_DATA, 8'h00, b, 8'h00);
        add_row(OP_STATUS, ADDR_STATUS, 8'h00, M_RX_EMPTY, M_RX_EMPTY | M_FRAME_ERR);
        add_row(OP_WRITE, ADDR_DIVISOR, 8'd3, 8'h00, 8'h00);
        add_row(OP_READ, ADDR_DIVISOR, 8'h00, 8'd3, 8'h00);
        b = DATA_BITS'($urandom);
        add_row(OP_TIMED, ADDR_DATA, b, 8'h00, 8'h00);
        add_row(OP_READ, ADDR_DATA, 8'h00, b, 8'h00);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    function automatic string status_name(input int b);
        case (b)
            ST_TX_FULL:  return "tx_full";
            ST_TX_EMPTY: return "tx_empty";
            ST_RX_EMPTY: return "rx_empty";
            ST_RX_FULL:  return "rx_full";
            ST_OVERRUN:  return "overrun";
            default:     return "frame_err";
        endcase
    endfunction

    task automatic check_data(input string name, input logic [DATA_BITS-1:0] got, exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s exp 0x%h got 0x%h", name, exp, got));
        end
    endtask

    task automatic check_status(input logic [DATA_BITS-1:0] got, exp, mask);
        for (int b = 0; b <= ST_FRAME_ERR; b++) begin
            if (mask[b] && got[b] !== exp[b]) begin
                stop_run($sformatf("ERR status.%s exp 0x%h got 0x%h (status 0x%h)",
                                   status_name(b), exp[b], got[b], got));
            end
        end
    endtask

    task automatic check_line(input logic got, exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR o_tx exp 0x%h got 0x%h", exp, got));
        end
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [DATA_BITS-1:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [DATA_BITS-1:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        @(posedge clk);
        while (!wb_ack) @(posedge clk);
        data = wb_dat_r;                          // Valid while ack is high
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic poll_status(input logic [DATA_BITS-1:0] mask, want);
        logic [DATA_BITS-1:0] st;
        read_reg(ADDR_STATUS, st);
        while ((st & mask) != (want & mask)) read_reg(ADDR_STATUS, st);
    endtask

    // 8N1 frame with its stop bit held low
    task automatic drive_bad_frame(input logic [DATA_BITS-1:0] data);
        int         bit_clks;
        logic [9:0] bits;
        bit_clks = OS_TICKS * (cur_div + 1);
        bits     = {1'b0, data, 1'b0};
        @(posedge clk);
        loop_en <= 1'b0;
        for (int i = 0; i < 10; i++) begin
            rx_drive <= bits[i];
            repeat (bit_clks) @(posedge clk);
        end
        rx_drive <= 1'b1;
        repeat (bit_clks) @(posedge clk);
        loop_en <= 1'b1;
    endtask

    task automatic apply_row(input row_t r);
        logic [DATA_BITS-1:0] got;
        longint               t0, took, lo, hi;
        case (r.op)
            OP_WRITE: begin
                write_reg(r.addr, r.wdata);
                if (r.addr == ADDR_DIVISOR) cur_div = r.wdata;  // High byte cleared
            end
            OP_READ: begin
                read_reg(r.addr, got);
                check_data("o_wb_dat", got, r.exp);
            end
            OP_STATUS: begin
                read_reg(ADDR_STATUS, got);
                check_status(got, r.exp, r.mask);
            end
            OP_POLL: poll_status(r.mask, r.exp);
            OP_SEND: begin
                poll_status(M_TX_FULL, 8'h00);
                write_reg(ADDR_DATA, r.wdata);
            end
            OP_LINE: begin
                @(posedge clk);
                check_line(dut_tx, r.wdata[0]);
            end
            OP_FRAME: drive_bad_frame(r.wdata);
            OP_TIMED: begin
                lo = 9 * OS_TICKS * (cur_div + 1);    // Mid stop bit is 9.5 bits in
                hi = 11 * OS_TICKS * (cur_div + 1);
                t0 = cycles;
                write_reg(ADDR_DATA, r.wdata);
                poll_status(M_RX_EMPTY, 8'h00);
                took = cycles - t0;
                if (took < lo || took > hi) begin
                    stop_run($sformatf("Byte at divisor %0d took %0d clocks, expected %0d to %0d",
                                       cur_div, took, lo, hi));
                end
            end
            default: stop_run("Unknown operation in stimulus table");
        endcase
    endtask

    task automatic watchdog(input longint limit_ns);
        #(limit_ns);
        $display("Run timed out after %0t, the DUT stopped making progress", $time);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    endtask

    initial begin
        longint limit_ns;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rx_drive = 1'b1;
        loop_en  = 1'b1;
        void'($urandom(32'he694_c3e7));
        build_table();
        limit_ns = longint'(rows.size()) * 12 * 10 * OS_TICKS * (max_div + 1) * 20;
        fork
            watchdog(limit_ns);
        join_none
        @(posedge clk);
        while (rst) @(posedge clk);
        foreach (rows[i]) apply_row(rows[i]);
        if (uart_top_i.uart_wb_regs_i.wb_props_i.fail_count == 0 &&
            uart_top_i.uart_transmitter_i.tx_props_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "Assertion failures during run");
        end
    end

endmodule

// File: testbench/uart_props.sv
`timescale 1ns/10ps

module uart_props (
    input logic i_clk,
    input logic i_reset,
    input logic i_cyc,
    input logic i_stb,
    input logic i_ack,
    input logic i_tx,
    input logic i_tx_idle
);
    int unsigned fail_count = 0;                  // Failed assertions so far

    ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset) i_ack |=> !i_ack)
        else begin
            fail_count++;
            $error("o_wb_ack stayed high for two cycles");
        end

    ack_after_stb: assert property (@(posedge i_clk) disable iff (i_reset)
        i_ack |-> $past(i_cyc && i_stb))
        else begin
            fail_count++;
            $error("o_wb_ack rose without a strobe");
        end

    // Serial line must idle high
    idle_line_high: assert property (@(posedge i_clk) disable iff (i_reset) i_tx_idle |-> i_tx)
        else begin
            fail_count++;
            $error("o_tx low while transmitter idle");
        end

endmodule

bind uart_wb_regs uart_props wb_props_i (
    .i_clk(i_clk), .i_reset(i_reset), .i_cyc(i_wb_cyc), .i_stb(i_wb_stb),
    .i_ack(o_wb_ack), .i_tx(1'b1), .i_tx_idle(1'b0)
);

bind uart_transmitter uart_props tx_props_i (
    .i_clk(i_clk), .i_reset(i_reset), .i_cyc(1'b0), .i_stb(1'b0),
    .i_ack(1'b0), .i_tx(o_tx), .i_tx_idle(state == uart_pkg::TX_IDLE)
);

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_reset
);
    initial begin
        o_clk = 1'b0;
        forever #10 o_clk = ~o_clk;               // 20 ns period
    end

    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_clk);
        o_reset <= 1'b0;
    end

endmodule

// File: src/uart_top.sv
`timescale 1ns/10ps

module uart_top (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [uart_pkg::WB_ADDR_WIDTH-1:0] i_wb_adr,
    input  logic [uart_pkg::DATA_BITS-1:0]     i_wb_dat,
    output logic [uart_pkg::DATA_BITS-1:0]     o_wb_dat,
    output logic                              o_wb_ack,
    input  logic                              i_rx,
    output logic                              o_tx
);
    import uart_pkg::*;

    logic                 tick;
    logic [DIV_WIDTH-1:0] divisor;
    logic                 tx_push, tx_taken, tx_full, tx_empty;
    logic [DATA_BITS-1:0] tx_wdata, tx_head;
    logic                 rx_valid, frame_err;
    logic [DATA_BITS-1:0] rx_byte;
    logic                 rx_push, rx_pop, rx_full, rx_empty;
    logic [DATA_BITS-1:0] rx_wdata, rx_head;

    uart_wb_regs uart_wb_regs_i (
        .i_clk      (i_clk),      .i_reset    (i_reset),
        .i_wb_cyc   (i_wb_cyc),   .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),    .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),   .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),   .o_tx_push  (tx_push),
        .o_tx_data  (tx_wdata),   .i_tx_full  (tx_full),
        .i_tx_empty (tx_empty),   .i_rx_valid (rx_valid),
        .i_rx_byte  (rx_byte),    .i_frame_err(frame_err),
        .o_rx_push  (rx_push),    .o_rx_wdata (rx_wdata),
        .o_rx_pop   (rx_pop),     .i_rx_head  (rx_head),
        .i_rx_empty (rx_empty),   .i_rx_full  (rx_full),
        .o_divisor  (divisor)
    );

    uart_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo (
        .i_clk  (i_clk),   .i_reset(i_reset),
        .i_push (tx_push), .i_data (tx_wdata),
        .i_pop  (tx_taken), .o_data (tx_head),
        .o_empty(tx_empty), .o_full (tx_full)
    );

    uart_fifo #(.DEPTH(RX_FIFO_DEPTH)) rx_fifo (
        .i_clk  (i_clk),    .i_reset(i_reset),
        .i_push (rx_push),  .i_data (rx_wdata),
        .i_pop  (rx_pop),   .o_data (rx_head),
        .o_empty(rx_empty), .o_full (rx_full)
    );

    uart_baud_gen uart_baud_gen_i (
        .i_clk(i_clk), .i_reset(i_reset), .i_divisor(divisor), .o_tick(tick)
    );

    uart_transmitter uart_transmitter_i (
        .i_clk     (i_clk),     .i_reset   (i_reset),
        .i_tx_start(~tx_empty), .i_bd_tick (tick),     // Start on any queued byte
        .i_data    (tx_head),   .o_tx_taken(tx_taken),
        .o_tx_done (),          .o_tx      (o_tx)
    );

    uart_receiver uart_receiver_i (
        .i_clk     (i_clk),    .i_reset    (i_reset),
        .i_rx      (i_rx),     .i_bd_tick  (tick),
        .o_rx_valid(rx_valid), .o_rx_data  (rx_byte),
        .o_frame_err(frame_err)
    );

endmodule

// File: src/uart_wb_regs.sv
`timescale 1ns/10ps

module uart_wb_regs (
    input  logic                              i_clk,
    input  logic                              i_reset,
    input  logic                              i_wb_cyc,
    input  logic                              i_wb_stb,
    input  logic                              i_wb_we,
    input  logic [uart_pkg::WB_ADDR_WIDTH-1:0] i_wb_adr,
    input  logic [uart_pkg::DATA_BITS-1:0]     i_wb_dat,
    output logic [uart_pkg::DATA_BITS-1:0]     o_wb_dat,
    output logic                              o_wb_ack,
    output logic                              o_tx_push,
    output logic [uart_pkg::DATA_BITS-1:0]     o_tx_data,
    input  logic                              i_tx_full,
    input  logic                              i_tx_empty,
    input  logic                              i_rx_valid,
    input  logic [uart_pkg::DATA_BITS-1:0]     i_rx_byte,
    input  logic                              i_frame_err,
    output logic                              o_rx_push,
    output logic [uart_pkg::DATA_BITS-1:0]     o_rx_wdata,
    output logic                              o_rx_pop,
    input  logic [uart_pkg::DATA_BITS-1:0]     i_rx_head,
    input  logic                              i_rx_empty,
    input  logic                              i_rx_full,
    output logic [uart_pkg::DIV_WIDTH-1:0]     o_divisor
);
    import uart_pkg::*;

    reg_addr_e            addr;
    logic                 wr_ack, rd_ack;     // One access strobe per transfer
    logic                 overrun, frame_err; // Sticky until status read
    logic [DATA_BITS-1:0] status;

    assign addr   = reg_addr_e'(i_wb_adr);
    assign wr_ack = o_wb_ack && i_wb_we;
    assign rd_ack = o_wb_ack && !i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wb_ack  <= 1'b0;
            o_divisor <= DIV_RESET;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            o_wb_ack <= i_wb_cyc && i_wb_stb && !o_wb_ack;  // Single-cycle ack
            if (wr_ack && addr == ADDR_DIVISOR) begin
                o_divisor <= DIV_WIDTH'(i_wb_dat);           // High byte cleared
            end
            if (rd_ack && addr == ADDR_STATUS) begin
                overrun   <= 1'b0;
                frame_err <= 1'b0;
            end
            // A new event wins over a clearing read
            if (i_rx_valid && i_rx_full) begin
                overrun <= 1'b1;
            end
            if (i_rx_valid && i_frame_err) begin
                frame_err <= 1'b1;
            end
        end
    end

    // The FIFOs drop a push when full
    assign o_tx_push  = wr_ack && (addr == ADDR_DATA);
    assign o_tx_data  = i_wb_dat;
    assign o_rx_push  = i_rx_valid;
    assign o_rx_wdata = i_rx_byte;
    assign o_rx_pop   = rd_ack && (addr == ADDR_DATA);

    always_comb begin
        status               = '0;
        status[ST_TX_FULL]   = i_tx_full;
        status[ST_TX_EMPTY]  = i_tx_empty;
        status[ST_RX_EMPTY]  = i_rx_empty;
        status[ST_RX_FULL]   = i_rx_full;
        status[ST_OVERRUN]   = overrun;
        status[ST_FRAME_ERR] = frame_err;
    end

    // Read data is valid during ack
    always_comb begin
        case (addr)
            ADDR_DATA:    o_wb_dat = i_rx_empty ? '0 : i_rx_head;
            ADDR_STATUS:  o_wb_dat = status;
            ADDR_DIVISOR: o_wb_dat = o_divisor[DATA_BITS-1:0];
            default:      o_wb_dat = '0;
        endcase
    end

endmodule

// File: src/uart_receiver.sv
`timescale 1ns/10ps

module uart_receiver (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_rx,
    input  logic                          i_bd_tick,
    output logic                          o_rx_valid,
    output logic [uart_pkg::DATA_BITS-1:0] o_rx_data,
    output logic                          o_frame_err
);
    import uart_pkg::*;

    logic                 rx_meta, rx_sync, rx_prev;
    logic                 rx_fall;
    rx_state_e            state, next_state;
    logic [TICK_W-1:0]    tick_cnt, next_tick_cnt;
    logic [BIT_W-1:0]     bit_cnt, next_bit_cnt;
    logic [DATA_BITS-1:0] shift_reg, next_shift_reg;

    // Two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign rx_fall = rx_prev && !rx_sync;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift_reg;
    end

    always_comb begin
        next_state     = state;
        next_tick_cnt  = tick_cnt;
        next_bit_cnt   = bit_cnt;
        next_shift_reg = shift_reg;
        o_rx_valid     = 1'b0;
        o_frame_err    = 1'b0;

        case (state)
            RX_IDLE: begin
                if (rx_fall) begin
                    next_state    = RX_START;
                    next_tick_cnt = '0;
                end
            end
            RX_START: begin
                if (i_bd_tick) begin
                    if (tick_cnt == OS_TICKS/2 - 1) begin
                        // High at mid start bit means a glitch
                        next_state    = rx_sync ? RX_IDLE : RX_DATA;
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            RX_DATA: begin
                if (i_bd_tick) begin
                    if (tick_cnt == OS_TICKS-1) begin
                        next_tick_cnt  = '0;
                        next_shift_reg = {rx_sync, shift_reg[DATA_BITS-1:1]};
                        if (bit_cnt == BIT_W'(DATA_BITS-1)) begin
                            next_state = RX_STOP;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            RX_STOP: begin
                if (i_bd_tick) begin
                    if (tick_cnt == OS_TICKS-1) begin  // Mid stop bit
                        next_state  = RX_IDLE;
                        o_rx_valid  = 1'b1;
                        o_frame_err = !rx_sync;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            default: next_state = RX_IDLE;
        endcase
    end

    assign o_rx_data = shift_reg;

endmodule

// File: src/uart_transmitter.sv
`timescale 1ns/10ps

module uart_transmitter (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_tx_start,
    input  logic                          i_bd_tick,
    input  logic [uart_pkg::DATA_BITS-1:0] i_data,
    output logic                          o_tx_taken,
    output logic                          o_tx_done,
    output logic                          o_tx
);
    import uart_pkg::*;

    tx_state_e            state, next_state;
    logic [TICK_W-1:0]    tick_cnt, next_tick_cnt;   // Ticks within current bit
    logic [BIT_W-1:0]     bit_cnt, next_bit_cnt;     // Data bit index
    logic [DATA_BITS-1:0] shift_reg, next_shift_reg;
    logic                 tx_reg, next_tx_reg;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_reg   <= 1'b1;                      // Line idles high
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
            tx_reg   <= next_tx_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift_reg;
    end

    always_comb begin
        next_state     = state;
        next_tick_cnt  = tick_cnt;
        next_bit_cnt   = bit_cnt;
        next_shift_reg = shift_reg;
        next_tx_reg    = tx_reg;
        o_tx_taken     = 1'b0;
        o_tx_done      = 1'b0;

        case (state)
            TX_IDLE: begin
                next_tx_reg = 1'b1;
                if (i_tx_start) begin
                    next_state     = TX_START;
                    next_tick_cnt  = '0;
                    next_shift_reg = i_data;       // Same edge as the FIFO pop
                    next_tx_reg    = 1'b0;         // Start bit goes out at once
                    o_tx_taken     = 1'b1;
                end
            end
            TX_START: begin
                if (i_bd_tick) begin
                    if (tick_cnt == OS_TICKS-1) begin
                        next_state    = TX_DATA;
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                        next_tx_reg   = shift_reg[0];
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            TX_DATA: begin
                if (i_bd_tick) begin
                    if (tick_cnt == OS_TICKS-1) begin
                        next_tick_cnt  = '0;
                        next_shift_reg = shift_reg >> 1;
                        if (bit_cnt == BIT_W'(DATA_BITS-1)) begin
                            next_state  = TX_STOP;
                            next_tx_reg = 1'b1;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                            next_tx_reg  = shift_reg[1];  // LSB first
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            TX_STOP: begin
                if (i_bd_tick) begin
                    if (tick_cnt == STOP_TICKS-1) begin
                        next_state = TX_IDLE;
                        o_tx_done  = 1'b1;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
            default: next_state = TX_IDLE;
        endcase
    end

    assign o_tx = tx_reg;

endmodule

// File: src/uart_fifo.sv
`timescale 1ns/10ps

module uart_fifo #(
    parameter int DEPTH = 8
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_push,
    input  logic [uart_pkg::DATA_BITS-1:0] i_data,
    input  logic                          i_pop,
    output logic [uart_pkg::DATA_BITS-1:0] o_data,
    output logic                          o_empty,
    output logic                          o_full
);
    import uart_pkg::*;

    logic [DATA_BITS-1:0]       mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]   wr_ptr;
    logic [$clog2(DEPTH)-1:0]   rd_ptr;
    logic [$clog2(DEPTH+1)-1:0] count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = i_push && !o_full;           // Push into a full FIFO is lost
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    assign o_data  = mem[rd_ptr];                 // First-word fall-through
    assign o_empty = (count == '0);
    assign o_full  = (count == DEPTH);

endmodule

// File: src/uart_baud_gen.sv
`timescale 1ns/10ps

module uart_baud_gen (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic [uart_pkg::DIV_WIDTH-1:0] i_divisor,
    output logic                          o_tick
);
    import uart_pkg::*;

    logic [DIV_WIDTH-1:0] count;                  // Clocks left until next tick

    // One tick every i_divisor+1 clocks
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else if (count == '0) begin
            count  <= i_divisor;                   // New divisor picked up here
            o_tick <= 1'b1;
        end else begin
            count  <= count - 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

    // Frame format
    localparam int DATA_BITS  = 8;
    localparam int BIT_W      = $clog2(DATA_BITS);
    localparam int OS_TICKS   = 16;                  // Oversampling ticks per bit
    localparam int STOP_TICKS = 16;
    localparam int TICK_W     = $clog2((OS_TICKS > STOP_TICKS) ? OS_TICKS : STOP_TICKS);

    // Baud divisor
    localparam int DIV_WIDTH = 16;
    localparam logic [DIV_WIDTH-1:0] DIV_RESET = 16'd1;  // Tick every 2 clocks

    localparam int TX_FIFO_DEPTH = 8;
    localparam int RX_FIFO_DEPTH = 16;

    // Word addressed host register map
    localparam int WB_ADDR_WIDTH = 2;

    typedef enum logic [WB_ADDR_WIDTH-1:0] {
        ADDR_DATA    = 2'd0,
        ADDR_STATUS  = 2'd1,
        ADDR_DIVISOR = 2'd2
    } reg_addr_e;

    // Status register bits
    localparam int ST_TX_FULL   = 0;
    localparam int ST_TX_EMPTY  = 1;
    localparam int ST_RX_EMPTY  = 2;
    localparam int ST_RX_FULL   = 3;
    localparam int ST_OVERRUN   = 4;
    localparam int ST_FRAME_ERR = 5;

    typedef enum logic [1:0] {
        TX_IDLE, TX_START, TX_DATA, TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE, RX_START, RX_DATA, RX_STOP
    } rx_state_e;

endpackage
